/* rtl/hcx_macros.svh */
`ifndef HCX_MACROS_SVH
`define HCX_MACROS_SVH

// ----------------------------------------------------------
// Datapath sizes
// ----------------------------------------------------------
`define HCX_HV_DIM        128
`define HCX_IM_ADDR_W     7
`define HCX_SHIFT_W       7
`define HCX_INST_DEPTH    32
`define HCX_INST_ADDR_W   5
`define HCX_INST_W        16
`define HCX_CSR_DATA_W    32
`define HCX_CSR_ADDR_W    4

// Base seed that every item is a rotation of
`define HCX_IM_SEED       128'h9E37_79B9_7F4A_7C15_F39C_C060_5CED_C834

// ----------------------------------------------------------
// CSR map
// ----------------------------------------------------------
`define HCX_CSR_CTRL      4'd0
`define HCX_CSR_STATUS    4'd1
`define HCX_CSR_INST_ADDR 4'd2
`define HCX_CSR_INST_DATA 4'd3
`define HCX_CSR_PC        4'd4

`endif

/* rtl/hcx_pkg.sv */
`include "hcx_macros.svh"

package hcx_pkg;

  // Opcodes with value 6 reserved as a no-op
  typedef enum logic [2:0] {
    OP_NOP     = 3'd0,
    OP_LOAD_A  = 3'd1,
    OP_BIND_AB = 3'd2,
    OP_BIND_A  = 3'd3,
    OP_PERM    = 3'd4,
    OP_EMIT    = 3'd5,
    OP_RSVD    = 3'd6,
    OP_END     = 3'd7
  } hcx_op_e;

  typedef struct packed {
    hcx_op_e                                 op;
    logic [`HCX_INST_W-4-`HCX_SHIFT_W:0]     unused;
    logic [`HCX_SHIFT_W-1:0]                 shift;
  } hcx_inst_t;

  typedef enum logic {
    SEQ_IDLE = 1'b0,
    SEQ_RUN  = 1'b1
  } hcx_seq_state_e;

  // Circular left rotation of a hypervector
  function automatic logic [`HCX_HV_DIM-1:0] hv_rotl(
    input logic [`HCX_HV_DIM-1:0] hv,
    input logic [`HCX_SHIFT_W-1:0] amt
  );
    logic [2*`HCX_HV_DIM-1:0] dbl;
    dbl = {hv, hv} << amt;
    return dbl[2*`HCX_HV_DIM-1:`HCX_HV_DIM];
  endfunction

endpackage

/* rtl/hcx_if.sv */
`timescale 1ns/1ps
`include "hcx_macros.svh"

// CSR block towards the sequencer
interface hcx_csr_if;
  logic                        start;
  logic                        inst_wr_en;
  logic [`HCX_INST_ADDR_W-1:0] inst_wr_addr;
  hcx_pkg::hcx_inst_t          inst_wr_data;
  logic                        busy;
  logic [`HCX_INST_ADDR_W-1:0] pc;

  modport csr (output start, inst_wr_en, inst_wr_addr, inst_wr_data, input busy, pc);
  modport seq (input start, inst_wr_en, inst_wr_addr, inst_wr_data, output busy, pc);
endinterface

// Decoded op from the sequencer, stall back from the encoder
interface hcx_ctrl_if;
  logic                    issue;
  hcx_pkg::hcx_op_e        op;
  logic [`HCX_SHIFT_W-1:0] shift_amt;
  logic                    stall;

  modport seq (output issue, op, shift_amt, input stall);
  modport enc (input issue, op, shift_amt, output stall);
endinterface

// Item hypervectors and pops between item memory and encoder
interface hcx_im_if;
  logic [`HCX_HV_DIM-1:0] hv_a;
  logic [`HCX_HV_DIM-1:0] hv_b;
  logic                   avail_a;
  logic                   avail_b;
  logic                   pop_a;
  logic                   pop_b;

  modport mem (output hv_a, hv_b, avail_a, avail_b, input pop_a, pop_b);
  modport enc (input hv_a, hv_b, avail_a, avail_b, output pop_a, pop_b);
endinterface

/* rtl/hcx_csr.sv */
`timescale 1ns/1ps
`include "hcx_macros.svh"

module hcx_csr (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic [`HCX_CSR_DATA_W-1:0] csr_req_data_i,
  input  logic [`HCX_CSR_ADDR_W-1:0] csr_req_addr_i,
  input  logic                       csr_req_write_i,
  input  logic                       csr_req_valid_i,
  output logic                       csr_req_ready_o,
  output logic [`HCX_CSR_DATA_W-1:0] csr_rsp_data_o,
  output logic                       csr_rsp_valid_o,
  input  logic                       csr_rsp_ready_i,
  hcx_csr_if.csr                     csr
);

  localparam int unsigned PadW = `HCX_CSR_DATA_W - `HCX_INST_ADDR_W;

  logic                        req_fire;
  logic                        wr_fire;
  logic [`HCX_CSR_DATA_W-1:0]  rd_data;
  logic                        rsp_valid_q;
  logic [`HCX_CSR_DATA_W-1:0]  rsp_data_q;
  logic [`HCX_INST_ADDR_W-1:0] inst_addr_q;
  logic                        start_q;
  logic                        wr_en_q;
  logic [`HCX_INST_ADDR_W-1:0] wr_addr_q;
  logic [`HCX_INST_W-1:0]      wr_data_q;

  // One outstanding request at a time
  assign csr_req_ready_o = !rsp_valid_q;
  assign req_fire        = csr_req_valid_i && csr_req_ready_o;
  assign wr_fire         = req_fire && csr_req_write_i;

  always_comb begin
    case (csr_req_addr_i)
      `HCX_CSR_STATUS:    rd_data = {{(`HCX_CSR_DATA_W-1){1'b0}}, csr.busy};
      `HCX_CSR_INST_ADDR: rd_data = {{PadW{1'b0}}, inst_addr_q};
      `HCX_CSR_PC:        rd_data = {{PadW{1'b0}}, csr.pc};
      default:            rd_data = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Response and control registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
      inst_addr_q <= '0;
      start_q     <= 1'b0;
      wr_en_q     <= 1'b0;
    end else begin
      if (req_fire) begin
        rsp_valid_q <= 1'b1;
      end else if (csr_rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      // Start is dropped while a program runs
      start_q <= wr_fire && (csr_req_addr_i == `HCX_CSR_CTRL) &&
                 csr_req_data_i[0] && !csr.busy;
      wr_en_q <= wr_fire && (csr_req_addr_i == `HCX_CSR_INST_DATA);
      if (wr_fire && (csr_req_addr_i == `HCX_CSR_INST_ADDR)) begin
        inst_addr_q <= csr_req_data_i[`HCX_INST_ADDR_W-1:0];
      end else if (wr_fire && (csr_req_addr_i == `HCX_CSR_INST_DATA)) begin
        inst_addr_q <= inst_addr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_data_q <= csr_req_write_i ? '0 : rd_data;
      wr_addr_q  <= inst_addr_q;
      wr_data_q  <= csr_req_data_i[`HCX_INST_W-1:0];
    end
  end

  assign csr_rsp_valid_o  = rsp_valid_q;
  assign csr_rsp_data_o   = rsp_data_q;
  assign csr.start        = start_q;
  assign csr.inst_wr_en   = wr_en_q;
  assign csr.inst_wr_addr = wr_addr_q;
  assign csr.inst_wr_data = wr_data_q;

  // Pending response holds until the host takes it
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    csr_rsp_valid_o && !csr_rsp_ready_i |=> csr_rsp_valid_o && $stable(csr_rsp_data_o))
    else $error("CSR response dropped or changed before acceptance");

endmodule

/* rtl/hcx_inst_seq.sv */
`timescale 1ns/1ps
`include "hcx_macros.svh"

module hcx_inst_seq (
  input  logic    clk_i,
  input  logic    arst_n_i,
  hcx_csr_if.seq  csr,
  hcx_ctrl_if.seq ctrl
);

  hcx_pkg::hcx_inst_t          inst_mem [`HCX_INST_DEPTH];
  hcx_pkg::hcx_inst_t          cur_inst;
  hcx_pkg::hcx_seq_state_e     state_q;
  logic [`HCX_INST_ADDR_W-1:0] pc_q;

  // Program store, written word by word from the CSR side
  always_ff @(posedge clk_i) begin
    if (csr.inst_wr_en) begin
      inst_mem[csr.inst_wr_addr] <= csr.inst_wr_data;
    end
  end

  assign cur_inst = inst_mem[pc_q];

  // ----------------------------------------------------------
  // Run control
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= hcx_pkg::SEQ_IDLE;
      pc_q    <= '0;
    end else begin
      case (state_q)
        hcx_pkg::SEQ_IDLE: begin
          if (csr.start) begin
            state_q <= hcx_pkg::SEQ_RUN;
            pc_q    <= '0;
          end
        end
        hcx_pkg::SEQ_RUN: begin
          if (!ctrl.stall) begin
            // pc parks on the END slot
            if (cur_inst.op == hcx_pkg::OP_END) begin
              state_q <= hcx_pkg::SEQ_IDLE;
            end else begin
              pc_q <= pc_q + 1'b1;
            end
          end
        end
        default: state_q <= hcx_pkg::SEQ_IDLE;
      endcase
    end
  end

  assign ctrl.issue     = (state_q == hcx_pkg::SEQ_RUN);
  assign ctrl.op        = cur_inst.op;
  assign ctrl.shift_amt = cur_inst.shift;
  assign csr.busy       = (state_q == hcx_pkg::SEQ_RUN);
  assign csr.pc         = pc_q;

  // Programs must end before running off the last slot
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ctrl.issue && !ctrl.stall && (ctrl.op != hcx_pkg::OP_END)
      |-> (pc_q < `HCX_INST_DEPTH - 1))
    else $error("Program counter advanced past the instruction memory");

endmodule

/* rtl/hcx_item_memory.sv */
`timescale 1ns/1ps
`include "hcx_macros.svh"

module hcx_item_memory (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic [`HCX_IM_ADDR_W-1:0] addr_a_i,
  input  logic [`HCX_IM_ADDR_W-1:0] addr_b_i,
  input  logic                      addr_a_valid_i,
  input  logic                      addr_b_valid_i,
  output logic                      addr_a_ready_o,
  output logic                      addr_b_ready_o,
  hcx_im_if.mem                     im
);

  logic [`HCX_IM_ADDR_W-1:0] addr [2];
  logic [`HCX_HV_DIM-1:0]    hv [2];
  logic [1:0]                addr_valid;
  logic [1:0]                addr_ready;
  logic [1:0]                pop;
  logic [1:0]                avail;

  // Index 0 is port A, index 1 is port B
  assign addr[0]       = addr_a_i;
  assign addr[1]       = addr_b_i;
  assign addr_valid    = {addr_b_valid_i, addr_a_valid_i};
  assign pop           = {im.pop_b, im.pop_a};
  assign addr_a_ready_o = addr_ready[0];
  assign addr_b_ready_o = addr_ready[1];
  assign im.hv_a       = hv[0];
  assign im.hv_b       = hv[1];
  assign im.avail_a    = avail[0];
  assign im.avail_b    = avail[1];

  for (genvar p = 0; p < 2; p++) begin : g_port
    logic                   vld_q;
    logic [`HCX_HV_DIM-1:0] hv_q;

    // Free slot, or the held item leaves this cycle
    assign addr_ready[p] = !vld_q || pop[p];
    assign avail[p]      = vld_q;
    assign hv[p]         = hv_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        vld_q <= 1'b0;
      end else if (addr_valid[p] && addr_ready[p]) begin
        vld_q <= 1'b1;
      end else if (pop[p]) begin
        vld_q <= 1'b0;
      end
    end

    always_ff @(posedge clk_i) begin
      if (addr_valid[p] && addr_ready[p]) begin
        hv_q <= hcx_pkg::hv_rotl(`HCX_IM_SEED, addr[p]);
      end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i) pop[p] |-> vld_q)
      else $error("Encoder popped an empty item port %0d", p);
  end

endmodule

/* rtl/hcx_encoder.sv */
`timescale 1ns/1ps
`include "hcx_macros.svh"

module hcx_encoder (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  hcx_ctrl_if.enc                ctrl,
  hcx_im_if.enc                  im,
  output logic [`HCX_HV_DIM-1:0] qhv_o,
  output logic                   qhv_valid_o,
  input  logic                   qhv_ready_i
);

  logic                   need_a;
  logic                   need_b;
  logic                   emit_block;
  logic                   exec;
  logic [`HCX_HV_DIM-1:0] acc_q;
  logic [`HCX_HV_DIM-1:0] qhv_q;
  logic                   qhv_valid_q;

  // ----------------------------------------------------------
  // Stall decision
  // ----------------------------------------------------------
  assign need_a = (ctrl.op == hcx_pkg::OP_LOAD_A) ||
                  (ctrl.op == hcx_pkg::OP_BIND_AB) ||
                  (ctrl.op == hcx_pkg::OP_BIND_A);
  assign need_b = (ctrl.op == hcx_pkg::OP_BIND_AB);

  // Query slot still full and not taken this cycle
  assign emit_block = (ctrl.op == hcx_pkg::OP_EMIT) && qhv_valid_q && !qhv_ready_i;

  assign ctrl.stall = ctrl.issue &&
                      ((need_a && !im.avail_a) || (need_b && !im.avail_b) || emit_block);
  assign exec       = ctrl.issue && !ctrl.stall;

  assign im.pop_a = exec && need_a;
  assign im.pop_b = exec && need_b;

  // ----------------------------------------------------------
  // Accumulator
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (exec) begin
      case (ctrl.op)
        hcx_pkg::OP_LOAD_A:  acc_q <= im.hv_a;
        hcx_pkg::OP_BIND_AB: acc_q <= im.hv_a ^ im.hv_b;
        hcx_pkg::OP_BIND_A:  acc_q <= acc_q ^ im.hv_a;
        hcx_pkg::OP_PERM:    acc_q <= hcx_pkg::hv_rotl(acc_q, ctrl.shift_amt);
        default:             acc_q <= acc_q;
      endcase
    end
  end

  // Query output register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      qhv_valid_q <= 1'b0;
    end else if (exec && (ctrl.op == hcx_pkg::OP_EMIT)) begin
      qhv_valid_q <= 1'b1;
    end else if (qhv_ready_i) begin
      qhv_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exec && (ctrl.op == hcx_pkg::OP_EMIT)) begin
      qhv_q <= acc_q;
    end
  end

  assign qhv_o       = qhv_q;
  assign qhv_valid_o = qhv_valid_q;

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    qhv_valid_o && !qhv_ready_i |=> qhv_valid_o && $stable(qhv_o))
    else $error("Query changed or vanished under back-pressure");

endmodule

/* rtl/hypercorex_top.sv */
`timescale 1ns/1ps
`include "hcx_macros.svh"

module hypercorex_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // CSR request and response
  input  logic [`HCX_CSR_DATA_W-1:0] csr_req_data_i,
  input  logic [`HCX_CSR_ADDR_W-1:0] csr_req_addr_i,
  input  logic                       csr_req_write_i,
  input  logic                       csr_req_valid_i,
  output logic                       csr_req_ready_o,
  output logic [`HCX_CSR_DATA_W-1:0] csr_rsp_data_o,
  output logic                       csr_rsp_valid_o,
  input  logic                       csr_rsp_ready_i,
  // Item address ports
  input  logic [`HCX_IM_ADDR_W-1:0]  addr_a_i,
  input  logic                       addr_a_valid_i,
  output logic                       addr_a_ready_o,
  input  logic [`HCX_IM_ADDR_W-1:0]  addr_b_i,
  input  logic                       addr_b_valid_i,
  output logic                       addr_b_ready_o,
  // Query output
  output logic [`HCX_HV_DIM-1:0]     qhv_o,
  output logic                       qhv_valid_o,
  input  logic                       qhv_ready_i
);

  hcx_csr_if  csr_bus ();
  hcx_ctrl_if ctrl_bus ();
  hcx_im_if   im_bus ();

  hcx_csr i_csr (
    .clk_i           ( clk_i           ),
    .arst_n_i        ( arst_n_i        ),
    .csr_req_data_i  ( csr_req_data_i  ),
    .csr_req_addr_i  ( csr_req_addr_i  ),
    .csr_req_write_i ( csr_req_write_i ),
    .csr_req_valid_i ( csr_req_valid_i ),
    .csr_req_ready_o ( csr_req_ready_o ),
    .csr_rsp_data_o  ( csr_rsp_data_o  ),
    .csr_rsp_valid_o ( csr_rsp_valid_o ),
    .csr_rsp_ready_i ( csr_rsp_ready_i ),
    .csr             ( csr_bus.csr     )
  );

  hcx_inst_seq i_inst_seq (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .csr      ( csr_bus.seq  ),
    .ctrl     ( ctrl_bus.seq )
  );

  hcx_item_memory i_item_memory (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .addr_a_i       ( addr_a_i       ),
    .addr_b_i       ( addr_b_i       ),
    .addr_a_valid_i ( addr_a_valid_i ),
    .addr_b_valid_i ( addr_b_valid_i ),
    .addr_a_ready_o ( addr_a_ready_o ),
    .addr_b_ready_o ( addr_b_ready_o ),
    .im             ( im_bus.mem     )
  );

  hcx_encoder i_encoder (
    .clk_i       ( clk_i        ),
    .arst_n_i    ( arst_n_i     ),
    .ctrl        ( ctrl_bus.enc ),
    .im          ( im_bus.enc   ),
    .qhv_o       ( qhv_o        ),
    .qhv_valid_o ( qhv_valid_o  ),
    .qhv_ready_i ( qhv_ready_i  )
  );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* tb/tb_hypercorex.sv */
`timescale 1ns/1ps
`include "hcx_macros.svh"

module tb_hypercorex;

  localparam int unsigned BindRuns      = 3;
  localparam int unsigned BindPairs     = 4;
  localparam int unsigned ChainRuns     = 4;
  // Instructions plus items per run
  localparam int unsigned BindUnits     = BindRuns * (4 * BindPairs + 1);
  localparam int unsigned ChainUnits    = ChainRuns * (5 + 2);
  localparam int unsigned TimeoutCycles = 16 + 200 * (BindUnits + ChainUnits);

  logic                       clk;
  logic                       arst_n;
  logic [`HCX_CSR_DATA_W-1:0] csr_req_data;
  logic [`HCX_CSR_ADDR_W-1:0] csr_req_addr;
  logic                       csr_req_write;
  logic                       csr_req_valid;
  logic                       csr_req_ready;
  logic [`HCX_CSR_DATA_W-1:0] csr_rsp_data;
  logic                       csr_rsp_valid;
  logic                       csr_rsp_ready;
  logic [`HCX_IM_ADDR_W-1:0]  addr_a;
  logic                       addr_a_valid;
  logic                       addr_a_ready;
  logic [`HCX_IM_ADDR_W-1:0]  addr_b;
  logic                       addr_b_valid;
  logic                       addr_b_ready;
  logic [`HCX_HV_DIM-1:0]     qhv;
  logic                       qhv_valid;
  logic                       qhv_ready;

  logic [`HCX_IM_ADDR_W-1:0]  a_q [$];
  logic [`HCX_IM_ADDR_W-1:0]  b_q [$];
  logic [`HCX_HV_DIM-1:0]     exp_q [$];
  logic [`HCX_INST_W-1:0]     prog [`HCX_INST_DEPTH];
  int                         prog_len;
  int                         error_count;
  int                         query_count;
  int                         sent_count;

  tb_clk_gen #(.PeriodNs(40), .ResetCycles(16)) i_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

  hypercorex_top dut_i (
    .clk_i           ( clk           ),
    .arst_n_i        ( arst_n        ),
    .csr_req_data_i  ( csr_req_data  ),
    .csr_req_addr_i  ( csr_req_addr  ),
    .csr_req_write_i ( csr_req_write ),
    .csr_req_valid_i ( csr_req_valid ),
    .csr_req_ready_o ( csr_req_ready ),
    .csr_rsp_data_o  ( csr_rsp_data  ),
    .csr_rsp_valid_o ( csr_rsp_valid ),
    .csr_rsp_ready_i ( csr_rsp_ready ),
    .addr_a_i        ( addr_a        ),
    .addr_a_valid_i  ( addr_a_valid  ),
    .addr_a_ready_o  ( addr_a_ready  ),
    .addr_b_i        ( addr_b        ),
    .addr_b_valid_i  ( addr_b_valid  ),
    .addr_b_ready_o  ( addr_b_ready  ),
    .qhv_o           ( qhv           ),
    .qhv_valid_o     ( qhv_valid     ),
    .qhv_ready_i     ( qhv_ready     )
  );

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic logic [`HCX_HV_DIM-1:0] rotate_left(
    input logic [`HCX_HV_DIM-1:0] v,
    input int unsigned amt
  );
    logic [`HCX_HV_DIM-1:0] r;
    for (int i = 0; i < `HCX_HV_DIM; i++) begin
      r[(i + amt) % `HCX_HV_DIM] = v[i];
    end
    return r;
  endfunction

  function automatic logic [`HCX_HV_DIM-1:0] item_hv(input int unsigned addr);
    return rotate_left(`HCX_IM_SEED, addr);
  endfunction

  // Opcode on top, shift in the low bits
  function automatic logic [`HCX_INST_W-1:0] encode_inst(
    input hcx_pkg::hcx_op_e op,
    input logic [`HCX_SHIFT_W-1:0] shift
  );
    return {op, 6'd0, shift};
  endfunction

  task automatic check_value(input string name, input logic [`HCX_HV_DIM-1:0] got,
                             input logic [`HCX_HV_DIM-1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s is %0h, expected %0h", name, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // CSR access
  // ----------------------------------------------------------
  task automatic csr_access(input logic write, input logic [`HCX_CSR_ADDR_W-1:0] addr,
                            input logic [`HCX_CSR_DATA_W-1:0] wdata,
                            output logic [`HCX_CSR_DATA_W-1:0] rdata);
    int unsigned hold;
    hold = $urandom % 3;
    @(posedge clk);
    csr_req_valid <= 1'b1;
    csr_req_write <= write;
    csr_req_addr  <= addr;
    csr_req_data  <= wdata;
    do @(posedge clk); while (!csr_req_ready);
    csr_req_valid <= 1'b0;
    // Host holds the response back for a while
    repeat (hold) @(posedge clk);
    csr_rsp_ready <= 1'b1;
    do @(posedge clk); while (!csr_rsp_valid);
    rdata = csr_rsp_data;
    csr_rsp_ready <= 1'b0;
  endtask

  task automatic csr_write(input logic [`HCX_CSR_ADDR_W-1:0] addr,
                           input logic [`HCX_CSR_DATA_W-1:0] wdata);
    logic [`HCX_CSR_DATA_W-1:0] rdata;
    csr_access(1'b1, addr, wdata, rdata);
    check_value("csr_rsp_data_o (write)", rdata, 0);
  endtask

  task automatic csr_read(input logic [`HCX_CSR_ADDR_W-1:0] addr,
                          output logic [`HCX_CSR_DATA_W-1:0] rdata);
    csr_access(1'b0, addr, '0, rdata);
  endtask

  task automatic load_program();
    csr_write(`HCX_CSR_INST_ADDR, 0);
    for (int i = 0; i < prog_len; i++) begin
      csr_write(`HCX_CSR_INST_DATA, prog[i]);
    end
  endtask

  task automatic expect_query(input logic [`HCX_HV_DIM-1:0] hv);
    exp_q.push_back(hv);
    sent_count++;
  endtask

  // Start, wait for every query, then check the idle state
  task automatic run_program(input int unsigned end_idx, input bit double_start);
    logic [`HCX_CSR_DATA_W-1:0] rdata;
    csr_write(`HCX_CSR_CTRL, 1);
    if (double_start) begin
      csr_write(`HCX_CSR_CTRL, 1);
    end
    while (exp_q.size() != 0) @(negedge clk);
    csr_read(`HCX_CSR_STATUS, rdata);
    check_value("status.busy", rdata, 0);
    csr_read(`HCX_CSR_PC, rdata);
    check_value("pc", rdata, end_idx);
    // Both item ports drained by the program
    check_value("addr_a_ready_o", addr_a_ready, 1);
    check_value("addr_b_ready_o", addr_b_ready, 1);
  endtask

  // ----------------------------------------------------------
  // Address feeders, query sink
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (!arst_n) begin
      addr_a_valid <= 1'b0;
    end else if (!addr_a_valid || addr_a_ready) begin
      if (a_q.size() != 0 && ($urandom % 4) != 0) begin
        addr_a       <= a_q.pop_front();
        addr_a_valid <= 1'b1;
      end else begin
        addr_a_valid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (!arst_n) begin
      addr_b_valid <= 1'b0;
    end else if (!addr_b_valid || addr_b_ready) begin
      if (b_q.size() != 0 && ($urandom % 4) != 0) begin
        addr_b       <= b_q.pop_front();
        addr_b_valid <= 1'b1;
      end else begin
        addr_b_valid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    qhv_ready <= arst_n && (($urandom % 3) != 0);
  end

  always @(posedge clk) begin
    if (arst_n && qhv_valid && qhv_ready) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("A query arrived while the model expected none");
      end else begin
        check_value("qhv_o", qhv, exp_q.pop_front());
        query_count++;
      end
    end
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout after %0d cycles, the programs did not finish", TimeoutCycles);
    $display("TEST FAIL");
    $finish;
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    logic [`HCX_CSR_DATA_W-1:0] rdata;
    logic [`HCX_INST_ADDR_W-1:0] rnd_addr;
    logic [`HCX_IM_ADDR_W-1:0]  ra;
    logic [`HCX_IM_ADDR_W-1:0]  rb;
    logic [`HCX_SHIFT_W-1:0]    shift;
    void'($urandom(29358));
    error_count   = 0;
    query_count   = 0;
    sent_count    = 0;
    prog_len      = 0;
    csr_req_data  = '0;
    csr_req_addr  = '0;
    csr_req_write = 1'b0;
    csr_req_valid = 1'b0;
    csr_rsp_ready = 1'b0;
    addr_a        = '0;
    addr_a_valid  = 1'b0;
    addr_b        = '0;
    addr_b_valid  = 1'b0;
    qhv_ready     = 1'b0;
    wait (arst_n === 1'b1);
    @(posedge clk);

    // After reset
    check_value("csr_req_ready_o", csr_req_ready, 1);
    check_value("csr_rsp_valid_o", csr_rsp_valid, 0);
    check_value("addr_a_ready_o", addr_a_ready, 1);
    check_value("addr_b_ready_o", addr_b_ready, 1);
    check_value("qhv_valid_o", qhv_valid, 0);
    csr_read(`HCX_CSR_STATUS, rdata);
    check_value("status", rdata, 0);
    csr_read(`HCX_CSR_PC, rdata);
    check_value("pc", rdata, 0);
    rnd_addr = $urandom % `HCX_INST_DEPTH;
    csr_write(`HCX_CSR_INST_ADDR, rnd_addr);
    csr_read(`HCX_CSR_INST_ADDR, rdata);
    check_value("inst_addr", rdata, rnd_addr);
    check_value("qhv_valid_o", qhv_valid, 0);

    // Bind program over several runs with a start while busy in the second
    for (int k = 0; k < BindPairs; k++) begin
      prog[2*k]   = encode_inst(hcx_pkg::OP_BIND_AB, 0);
      prog[2*k+1] = encode_inst(hcx_pkg::OP_EMIT, 0);
    end
    prog[2*BindPairs] = encode_inst(hcx_pkg::OP_END, 0);
    prog_len = 2 * BindPairs + 1;
    load_program();
    for (int r = 0; r < BindRuns; r++) begin
      @(negedge clk);
      for (int k = 0; k < BindPairs; k++) begin
        ra = $urandom % 128;
        rb = $urandom % 128;
        a_q.push_back(ra);
        b_q.push_back(rb);
        expect_query(item_hv(ra) ^ item_hv(rb));
      end
      run_program(2 * BindPairs, r == 1);
    end

    // Chain program with a fresh shift each run
    for (int r = 0; r < ChainRuns; r++) begin
      shift   = $urandom % 128;
      prog[0] = encode_inst(hcx_pkg::OP_LOAD_A, 0);
      prog[1] = encode_inst(hcx_pkg::OP_PERM, shift);
      prog[2] = encode_inst(hcx_pkg::OP_BIND_A, 0);
      prog[3] = encode_inst(hcx_pkg::OP_EMIT, 0);
      prog[4] = encode_inst(hcx_pkg::OP_END, 0);
      prog_len = 5;
      load_program();
      @(negedge clk);
      ra = $urandom % 128;
      rb = $urandom % 128;
      a_q.push_back(ra);
      a_q.push_back(rb);
      expect_query(rotate_left(item_hv(ra), shift) ^ item_hv(rb));
      run_program(4, 1'b0);
    end

    check_value("query count", query_count, sent_count);
    $display("Run complete: %0d errors, %0d of %0d queries checked",
             error_count, query_count, sent_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* hypercorex.f */
+incdir+rtl
rtl/hcx_pkg.sv
rtl/hcx_if.sv
rtl/hcx_csr.sv
rtl/hcx_inst_seq.sv
rtl/hcx_item_memory.sv
rtl/hcx_encoder.sv
rtl/hypercorex_top.sv
tb/tb_clk_gen.sv
tb/tb_hypercorex.sv

/* Bender.yml */
package:
  name: hypercorex

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/hcx_pkg.sv
      - rtl/hcx_if.sv
      - rtl/hcx_csr.sv
      - rtl/hcx_inst_seq.sv
      - rtl/hcx_item_memory.sv
      - rtl/hcx_encoder.sv
      - rtl/hypercorex_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_hypercorex.sv
